//--- design/exec_stage.sv
`timescale 1ns/1ps
`default_nettype none

module exec_stage import rv_core_pkg::*; (
   input  logic      i_clk,
   input  logic      i_reset,
   input  dec_ctrl_t i_ctrl,
   input  xlen_t     i_rs1_val,
   input  xlen_t     i_rs2_val,
   output ex_pkt_t   o_ex,
   output logic      o_fwd_we,
   output reg_addr_t o_fwd_rd,
   output xlen_t     o_fwd_data
);

   dec_ctrl_t  r_ctrl;
   xlen_t      r_rs1;
   xlen_t      r_rs2;
   xlen_t      op_a;
   xlen_t      op_b;
   xlen_t      shift_src;
   logic [5:0] sh;
   xlen_t      res;

   always_ff @(posedge i_clk) begin
      if (i_reset)
         r_ctrl <= '0;
      else
         r_ctrl <= i_ctrl;
   end

   always_ff @(posedge i_clk) begin
      r_rs1 <= i_rs1_val;
      r_rs2 <= i_rs2_val;
   end

   always_comb begin
      op_a = r_ctrl.rs1_re ? r_rs1 : '0;
      case (r_ctrl.op_sel)
         OP_RF:    op_b = r_ctrl.rs2_re ? r_rs2 : '0;
         OP_IMM20: op_b = {r_ctrl.imm[51:0], 12'd0};
         default:  op_b = r_ctrl.imm;
      endcase

      // word shifts work on the low half, widened so the low 32 result bits come out right
      if (r_ctrl.word_op)
         shift_src = (r_ctrl.alu_op == ALU_SRA) ? {{32{op_a[31]}}, op_a[31:0]} :
                                                  {32'd0, op_a[31:0]};
      else
         shift_src = op_a;
      sh = r_ctrl.word_op ? {1'b0, op_b[4:0]} : op_b[5:0];

      case (r_ctrl.alu_op)
         ALU_SUB:  res = op_a - op_b;
         ALU_SLT:  res = {63'd0, $signed(op_a) < $signed(op_b)};
         ALU_SLTU: res = {63'd0, op_a < op_b};
         ALU_XOR:  res = op_a ^ op_b;
         ALU_OR:   res = op_a | op_b;
         ALU_AND:  res = op_a & op_b;
         ALU_SLL:  res = shift_src << sh;
         ALU_SRL:  res = shift_src >> sh;
         ALU_SRA:  res = xlen_t'($signed(shift_src) >>> sh);
         ALU_LUI:  res = op_b;
         default:  res = op_a + op_b;
      endcase
      if (r_ctrl.word_op)
         res = {{32{res[31]}}, res[31:0]};
   end

   assign o_ex.valid      = r_ctrl.valid;
   assign o_ex.illegal    = r_ctrl.illegal;
   assign o_ex.rf_we      = r_ctrl.rf_we;
   assign o_ex.rd         = r_ctrl.rd;
   assign o_ex.load       = r_ctrl.load;
   assign o_ex.store      = r_ctrl.store;
   assign o_ex.lsu_size   = r_ctrl.lsu_size;
   assign o_ex.lsu_sigext = r_ctrl.lsu_sigext;
   assign o_ex.result     = res;
   assign o_ex.store_data = r_rs2;

   assign o_fwd_we   = r_ctrl.valid & r_ctrl.rf_we & ~r_ctrl.load;  // load data is not ready yet
   assign o_fwd_rd   = r_ctrl.rd;
   assign o_fwd_data = res;

endmodule

`default_nettype wire

//--- design/insn_decode.sv
`timescale 1ns/1ps
`default_nettype none

module insn_decode import rv_core_pkg::*; (
   input  insn_t     i_insn,
   input  logic      i_valid,
   output dec_ctrl_t o_ctrl
);

   localparam logic [6:0] OPC_LUI    = 7'b0110111;
   localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [6:0] OPC_OP     = 7'b0110011;
   localparam logic [6:0] OPC_IMM32  = 7'b0011011;
   localparam logic [6:0] OPC_OP32   = 7'b0111011;
   localparam logic [6:0] OPC_LOAD   = 7'b0000011;
   localparam logic [6:0] OPC_STORE  = 7'b0100011;

   logic [6:0] opcode;
   logic [2:0] funct3;
   logic [6:0] funct7;
   reg_addr_t  rd;
   logic       alt;
   xlen_t      imm_i;
   xlen_t      imm_s;
   xlen_t      imm_u;
   logic [5:0] shamt;
   logic       legal;
   logic       writes;
   logic       is_load;
   logic       is_store;

   assign opcode = i_insn[6:0];
   assign rd     = i_insn[11:7];
   assign funct3 = i_insn[14:12];
   assign funct7 = i_insn[31:25];
   assign alt    = i_insn[30];

   assign imm_i = {{52{i_insn[31]}}, i_insn[31:20]};
   assign imm_s = {{52{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
   assign imm_u = {{44{i_insn[31]}}, i_insn[31:12]};

   // word shifts only have a 5-bit amount, bit 25 belongs to funct7 there
   assign shamt = (opcode == OPC_IMM32) ? {1'b0, i_insn[24:20]} : i_insn[25:20];

   function automatic alu_op_t alu_of(logic [2:0] f3, logic alt_op);
      case (f3)
         3'b000:  return alt_op ? ALU_SUB : ALU_ADD;
         3'b001:  return ALU_SLL;
         3'b010:  return ALU_SLT;
         3'b011:  return ALU_SLTU;
         3'b100:  return ALU_XOR;
         3'b101:  return alt_op ? ALU_SRA : ALU_SRL;
         3'b110:  return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   always_comb begin
      legal             = 1'b0;
      writes            = 1'b0;
      is_load           = 1'b0;
      is_store          = 1'b0;
      o_ctrl.rs1_re     = 1'b0;
      o_ctrl.rs2_re     = 1'b0;
      o_ctrl.alu_op     = ALU_ADD;  // also the address adder for loads and stores
      o_ctrl.op_sel     = OP_IMM12;
      o_ctrl.word_op    = 1'b0;
      o_ctrl.imm        = imm_i;
      o_ctrl.lsu_size   = funct3[1:0];
      o_ctrl.lsu_sigext = ~funct3[2];
      case (opcode)
         OPC_LUI: begin
            legal         = 1'b1;
            writes        = 1'b1;
            o_ctrl.alu_op = ALU_LUI;
            o_ctrl.op_sel = OP_IMM20;
            o_ctrl.imm    = imm_u;
         end
         OPC_OP_IMM, OPC_IMM32: begin
            writes         = 1'b1;
            o_ctrl.rs1_re  = 1'b1;
            o_ctrl.word_op = (opcode == OPC_IMM32);
            o_ctrl.alu_op  = alu_of(funct3, alt & (funct3 == 3'b101));
            if (funct3 == 3'b001 || funct3 == 3'b101) begin
               o_ctrl.imm = {58'd0, shamt};
               if (o_ctrl.word_op)
                  legal = (funct7 == {1'b0, alt & funct3[2], 5'd0});
               else
                  legal = (i_insn[31:26] == {1'b0, alt & funct3[2], 4'd0});
            end else begin
               legal = ~o_ctrl.word_op | (funct3 == 3'b000);
            end
         end
         OPC_OP, OPC_OP32: begin
            writes         = 1'b1;
            o_ctrl.rs1_re  = 1'b1;
            o_ctrl.rs2_re  = 1'b1;
            o_ctrl.op_sel  = OP_RF;
            o_ctrl.word_op = (opcode == OPC_OP32);
            o_ctrl.alu_op  = alu_of(funct3, alt);
            legal = (funct7 == 7'd0) |
                    ((funct7 == 7'b0100000) & (funct3 == 3'b000 | funct3 == 3'b101));
            if (o_ctrl.word_op && !(funct3 == 3'b000 || funct3 == 3'b001 || funct3 == 3'b101))
               legal = 1'b0;
         end
         OPC_LOAD: begin
            legal         = (funct3 != 3'b111);
            writes        = 1'b1;
            is_load       = 1'b1;
            o_ctrl.rs1_re = 1'b1;
         end
         OPC_STORE: begin
            legal         = ~funct3[2];
            is_store      = 1'b1;
            o_ctrl.rs1_re = 1'b1;
            o_ctrl.rs2_re = 1'b1;
            o_ctrl.imm    = imm_s;
         end
         default: legal = 1'b0;
      endcase

      o_ctrl.valid   = i_valid;
      o_ctrl.illegal = i_valid & ~legal;
      o_ctrl.rf_we   = i_valid & legal & writes & (rd != 5'd0);
      o_ctrl.load    = i_valid & legal & is_load;
      o_ctrl.store   = i_valid & legal & is_store;
      o_ctrl.rd      = rd;
      o_ctrl.rs1     = i_insn[19:15];
      o_ctrl.rs2     = i_insn[24:20];
   end

endmodule

`default_nettype wire

//--- design/lsu.sv
`timescale 1ns/1ps
`default_nettype none

module lsu import rv_core_pkg::*; #(
   parameter int DMEM_WORDS = 256
) (
   input  logic    i_clk,
   input  logic    i_reset,
   input  ex_pkt_t i_ex,
   output wb_pkt_t o_wb
);

   localparam int AW = $clog2(DMEM_WORDS);

   xlen_t          mem [DMEM_WORDS];
   logic [AW-1:0]  idx;
   logic [2:0]     off;
   logic [7:0]     be;
   xlen_t          wdata;
   xlen_t          rdata;
   ex_pkt_t        r_ex;
   xlen_t          lane;
   xlen_t          ld_val;

   assign idx   = i_ex.result[AW+2:3];  // byte address wraps at the memory size
   assign off   = i_ex.result[2:0];
   assign wdata = i_ex.store_data << {off, 3'b000};

   always_comb begin
      case (i_ex.lsu_size)
         LSU_B: be = 8'h01 << off;
         LSU_H: be = 8'h03 << off;
         LSU_W: be = 8'h0f << off;
         LSU_D: be = 8'hff;
      endcase
   end

   always_ff @(posedge i_clk) begin
      if (i_ex.valid && i_ex.store) begin
         for (int b = 0; b < 8; b++) begin
            if (be[b])
               mem[idx][b*8 +: 8] <= wdata[b*8 +: 8];
         end
      end
      rdata <= mem[idx];  // old contents on a same-edge write, only loads look at it
   end

   always_ff @(posedge i_clk) begin
      if (i_reset)
         r_ex <= '0;
      else
         r_ex <= i_ex;
   end

   assign lane = rdata >> {r_ex.result[2:0], 3'b000};

   always_comb begin
      case (r_ex.lsu_size)
         LSU_B: ld_val = r_ex.lsu_sigext ? {{56{lane[7]}}, lane[7:0]} : {56'd0, lane[7:0]};
         LSU_H: ld_val = r_ex.lsu_sigext ? {{48{lane[15]}}, lane[15:0]} : {48'd0, lane[15:0]};
         LSU_W: ld_val = r_ex.lsu_sigext ? {{32{lane[31]}}, lane[31:0]} : {32'd0, lane[31:0]};
         LSU_D: ld_val = lane;
      endcase
   end

   assign o_wb.valid   = r_ex.valid;
   assign o_wb.illegal = r_ex.illegal;
   assign o_wb.we      = r_ex.rf_we & ~r_ex.store;
   assign o_wb.rd      = r_ex.rd;
   assign o_wb.data    = r_ex.load ? ld_val : r_ex.result;

endmodule

`default_nettype wire

//--- design/operand_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module operand_fetch import rv_core_pkg::*; (
   input  logic      i_clk,
   input  reg_addr_t i_rs1,
   input  reg_addr_t i_rs2,
   input  logic      i_ex_fwd_we,
   input  reg_addr_t i_ex_fwd_rd,
   input  xlen_t     i_ex_fwd_data,
   input  wb_pkt_t   i_wb,
   output xlen_t     o_rs1_val,
   output xlen_t     o_rs2_val
);

   xlen_t rf [32];
   logic  wb_hit_ok;

   assign wb_hit_ok = i_wb.valid & i_wb.we & (i_wb.rd != 5'd0);

   always_ff @(posedge i_clk) begin
      if (wb_hit_ok)
         rf[i_wb.rd] <= i_wb.data;
   end

   // execute result first, then writeback, then the array
   function automatic xlen_t read_port(reg_addr_t addr);
      if (addr == 5'd0)
         return '0;
      else if (i_ex_fwd_we && i_ex_fwd_rd == addr)
         return i_ex_fwd_data;
      else if (wb_hit_ok && i_wb.rd == addr)
         return i_wb.data;
      else
         return rf[addr];
   endfunction

   always_comb begin
      o_rs1_val = read_port(i_rs1);
      o_rs2_val = read_port(i_rs2);
   end

endmodule

`default_nettype wire

//--- design/rv_core_pkg.sv
`default_nettype none

package rv_core_pkg;

   typedef logic [63:0] xlen_t;
   typedef logic [31:0] insn_t;
   typedef logic [4:0]  reg_addr_t;
   typedef logic [3:0]  alu_op_t;
   typedef logic [1:0]  op_sel_t;
   typedef logic [1:0]  lsu_size_t;  // log2 of the access size in bytes

   localparam alu_op_t ALU_ADD  = 4'd0;
   localparam alu_op_t ALU_SUB  = 4'd1;
   localparam alu_op_t ALU_SLT  = 4'd2;
   localparam alu_op_t ALU_SLTU = 4'd3;
   localparam alu_op_t ALU_XOR  = 4'd4;
   localparam alu_op_t ALU_OR   = 4'd5;
   localparam alu_op_t ALU_AND  = 4'd6;
   localparam alu_op_t ALU_SLL  = 4'd7;
   localparam alu_op_t ALU_SRL  = 4'd8;
   localparam alu_op_t ALU_SRA  = 4'd9;
   localparam alu_op_t ALU_LUI  = 4'd10;  // passes the second operand through

   localparam op_sel_t OP_RF    = 2'd0;
   localparam op_sel_t OP_IMM12 = 2'd1;
   localparam op_sel_t OP_IMM20 = 2'd2;  // execute shifts the U immediate left by 12

   localparam lsu_size_t LSU_B = 2'd0;
   localparam lsu_size_t LSU_H = 2'd1;
   localparam lsu_size_t LSU_W = 2'd2;
   localparam lsu_size_t LSU_D = 2'd3;

   typedef struct packed {
      logic      valid;
      logic      illegal;
      logic      rf_we;
      reg_addr_t rd;
      reg_addr_t rs1;
      reg_addr_t rs2;
      logic      rs1_re;
      logic      rs2_re;
      alu_op_t   alu_op;
      op_sel_t   op_sel;
      logic      word_op;  // 32-bit operation, result sign-extended from bit 31
      xlen_t     imm;
      logic      load;
      logic      store;
      lsu_size_t lsu_size;
      logic      lsu_sigext;
   } dec_ctrl_t;

   typedef struct packed {
      logic      valid;
      logic      illegal;
      logic      rf_we;
      reg_addr_t rd;
      logic      load;
      logic      store;
      lsu_size_t lsu_size;
      logic      lsu_sigext;
      xlen_t     result;  // ALU result, or the byte address for loads and stores
      xlen_t     store_data;
   } ex_pkt_t;

   typedef struct packed {
      logic      valid;
      logic      illegal;
      logic      we;
      reg_addr_t rd;
      xlen_t     data;
   } wb_pkt_t;

endpackage

`default_nettype wire

//--- design/rv_exec_top.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_top import rv_core_pkg::*; #(
   parameter int DMEM_WORDS = 256
) (
   input  logic      i_clk,
   input  logic      i_reset,
   input  logic      i_valid,
   input  insn_t     i_insn,
   output logic      o_wb_valid,
   output logic      o_wb_illegal,
   output logic      o_wb_we,
   output reg_addr_t o_wb_rd,
   output xlen_t     o_wb_data
);

   dec_ctrl_t dec_ctrl;
   xlen_t     rs1_val;
   xlen_t     rs2_val;
   ex_pkt_t   ex_pkt;
   logic      fwd_we;
   reg_addr_t fwd_rd;
   xlen_t     fwd_data;
   wb_pkt_t   wb_pkt;

   insn_decode u_decode (
      .i_insn  (i_insn),
      .i_valid (i_valid),
      .o_ctrl  (dec_ctrl)
   );

   operand_fetch u_operand_fetch (
      .i_clk         (i_clk),
      .i_rs1         (dec_ctrl.rs1),
      .i_rs2         (dec_ctrl.rs2),
      .i_ex_fwd_we   (fwd_we),
      .i_ex_fwd_rd   (fwd_rd),
      .i_ex_fwd_data (fwd_data),
      .i_wb          (wb_pkt),
      .o_rs1_val     (rs1_val),
      .o_rs2_val     (rs2_val)
   );

   exec_stage u_exec (
      .i_clk      (i_clk),
      .i_reset    (i_reset),
      .i_ctrl     (dec_ctrl),
      .i_rs1_val  (rs1_val),
      .i_rs2_val  (rs2_val),
      .o_ex       (ex_pkt),
      .o_fwd_we   (fwd_we),
      .o_fwd_rd   (fwd_rd),
      .o_fwd_data (fwd_data)
   );

   lsu #(
      .DMEM_WORDS (DMEM_WORDS)
   ) u_lsu (
      .i_clk   (i_clk),
      .i_reset (i_reset),
      .i_ex    (ex_pkt),
      .o_wb    (wb_pkt)
   );

   assign o_wb_valid   = wb_pkt.valid;
   assign o_wb_illegal = wb_pkt.illegal;
   assign o_wb_we      = wb_pkt.we;
   assign o_wb_rd      = wb_pkt.rd;
   assign o_wb_data    = wb_pkt.data;

endmodule

`default_nettype wire

//--- dv/rv_exec_chk.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_chk import rv_core_pkg::*; (
   input logic      i_clk,
   input logic      i_reset,
   input logic      i_valid,
   input dec_ctrl_t i_dec,
   input ex_pkt_t   i_ex,
   input logic      i_wb_valid,
   input logic      i_wb_we,
   input reg_addr_t i_wb_rd
);

   int fail_count = 0;

   a_wb_idle_after_reset: assert property (@(posedge i_clk) i_reset |=> !i_wb_valid)
      else begin
         $error("o_wb_valid high right after reset");
         fail_count++;
      end

   a_wb_two_cycles: assert property (@(posedge i_clk) disable iff (i_reset)
      i_valid |-> ##2 i_wb_valid)
      else begin
         $error("issued instruction did not write back two cycles later");
         fail_count++;
      end

   a_no_x0_write: assert property (@(posedge i_clk) disable iff (i_reset)
      (i_wb_valid && i_wb_we) |-> (i_wb_rd != 5'd0))
      else begin
         $error("writeback targets x0");
         fail_count++;
      end

   // a load in execute cannot forward, so the next instruction must not read its rd
   a_load_use: assert property (@(posedge i_clk) disable iff (i_reset)
      (i_ex.valid && i_ex.load && i_ex.rf_we && i_dec.valid) |->
      !((i_dec.rs1_re && i_dec.rs1 == i_ex.rd) || (i_dec.rs2_re && i_dec.rs2 == i_ex.rd)))
      else begin
         $error("instruction reads the destination of the load just before it");
         fail_count++;
      end

endmodule

bind rv_exec_top rv_exec_chk u_chk (
   .i_clk      (i_clk),
   .i_reset    (i_reset),
   .i_valid    (i_valid),
   .i_dec      (dec_ctrl),
   .i_ex       (ex_pkt),
   .i_wb_valid (o_wb_valid),
   .i_wb_we    (o_wb_we),
   .i_wb_rd    (o_wb_rd)
);

`default_nettype wire

//--- dv/rv_exec_mon.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_mon import rv_core_pkg::*; #(
   parameter int DMEM_WORDS = 256
) (
   input  logic      i_clk,
   input  logic      i_reset,
   input  logic      i_valid,
   input  insn_t     i_insn,
   input  logic      i_wb_valid,
   input  logic      i_wb_illegal,
   input  logic      i_wb_we,
   input  reg_addr_t i_wb_rd,
   input  xlen_t     i_wb_data,
   output int        o_errors,
   output int        o_checked,
   output int        o_pending
);

   xlen_t   regs [32];
   xlen_t   dmem [DMEM_WORDS];
   insn_t   issued [$];
   int      issue_cyc [$];
   int      cyc;
   int      when;
   insn_t   insn;
   wb_pkt_t want;

   function automatic xlen_t alu_result(logic [2:0] f3, logic alt, xlen_t a, xlen_t b,
                                        logic word);
      logic [5:0]  sh;
      logic [31:0] lo;
      sh = word ? {1'b0, b[4:0]} : b[5:0];
      if (word) begin
         if (f3 == 3'b001)
            lo = a[31:0] << sh;
         else if (f3 == 3'b101 && alt)
            lo = $signed(a[31:0]) >>> sh;
         else if (f3 == 3'b101)
            lo = a[31:0] >> sh;
         else
            lo = alt ? a[31:0] - b[31:0] : a[31:0] + b[31:0];
         return {{32{lo[31]}}, lo};
      end
      case (f3)
         3'b000:  return alt ? a - b : a + b;
         3'b001:  return a << sh;
         3'b010:  return {63'd0, $signed(a) < $signed(b)};
         3'b011:  return {63'd0, a < b};
         3'b100:  return a ^ b;
         3'b101:  if (alt) return $signed(a) >>> sh; else return a >> sh;
         3'b110:  return a | b;
         default: return a & b;
      endcase
   endfunction

   function automatic xlen_t load_value(xlen_t addr, logic [2:0] f3);
      xlen_t w;
      w = dmem[(addr >> 3) % DMEM_WORDS] >> (8 * addr[2:0]);
      case (f3)
         3'b000:  return {{56{w[7]}}, w[7:0]};
         3'b001:  return {{48{w[15]}}, w[15:0]};
         3'b010:  return {{32{w[31]}}, w[31:0]};
         3'b100:  return {56'd0, w[7:0]};
         3'b101:  return {48'd0, w[15:0]};
         3'b110:  return {32'd0, w[31:0]};
         default: return w;
      endcase
   endfunction

   // expected writeback of one instruction against the current architectural state
   function automatic wb_pkt_t ref_wb(insn_t ins);
      wb_pkt_t    e;
      logic [6:0] opc;
      logic [2:0] f3;
      logic [6:0] f7;
      xlen_t      a;
      xlen_t      imm;
      xlen_t      r;
      logic       ok;
      logic       wr;
      opc = ins[6:0];
      f3  = ins[14:12];
      f7  = ins[31:25];
      a   = regs[ins[19:15]];
      imm = {{52{ins[31]}}, ins[31:20]};
      ok  = 1'b0;
      wr  = 1'b1;
      r   = '0;
      case (opc)
         7'b0110111: begin
            ok = 1'b1;
            r  = {{32{ins[31]}}, ins[31:12], 12'd0};
         end
         7'b0010011: begin
            ok = (f3 == 3'b001) ? (ins[31:26] == 6'd0) :
                 (f3 == 3'b101) ? (ins[31:26] == 6'd0 || ins[31:26] == 6'b010000) : 1'b1;
            r  = alu_result(f3, f3 == 3'b101 && ins[30], a, imm, 1'b0);
         end
         7'b0011011: begin
            ok = (f3 == 3'b000) || (f3 == 3'b001 && f7 == 7'd0) ||
                 (f3 == 3'b101 && (f7 == 7'd0 || f7 == 7'b0100000));
            r  = alu_result(f3, f3 == 3'b101 && ins[30], a, imm, 1'b1);
         end
         7'b0110011, 7'b0111011: begin
            ok = (f7 == 7'd0) || (f7 == 7'b0100000 && (f3 == 3'b000 || f3 == 3'b101));
            if (opc[3] && !(f3 == 3'b000 || f3 == 3'b001 || f3 == 3'b101))
               ok = 1'b0;  // OP-32 has only add, sub and the shifts
            r  = alu_result(f3, ins[30], a, regs[ins[24:20]], opc[3]);
         end
         7'b0000011: begin
            ok = (f3 != 3'b111);
            r  = load_value(a + imm, f3);
         end
         7'b0100011: begin
            ok = ~f3[2];
            wr = 1'b0;
         end
         default: ok = 1'b0;
      endcase
      e.valid   = 1'b1;
      e.illegal = ~ok;
      e.we      = ok & wr & (ins[11:7] != 5'd0);
      e.rd      = ins[11:7];
      e.data    = r;
      return e;
   endfunction

   task automatic apply_store(insn_t ins);
      xlen_t addr;
      xlen_t data;
      int    i;
      addr = regs[ins[19:15]] + {{52{ins[31]}}, ins[31:25], ins[11:7]};
      data = regs[ins[24:20]];
      for (i = 0; i < (1 << ins[13:12]); i++)
         dmem[(addr >> 3) % DMEM_WORDS][(addr[2:0] + i) * 8 +: 8] = data[i*8 +: 8];
   endtask

   task automatic compare_field(string name, xlen_t expected, xlen_t actual);
      if (expected !== actual) begin
         o_errors++;
         $display("[FAIL] %s expected 0x%0h got 0x%0h (insn 0x%08h)", name, expected, actual,
                  insn);
      end
   endtask

   always @(posedge i_clk) begin
      if (i_reset) begin
         issued.delete();
         issue_cyc.delete();
         regs[0]   = '0;
         cyc       = 0;
         o_errors  = 0;
         o_checked = 0;
      end else begin
         if (i_wb_valid && issued.size() == 0) begin
            o_errors++;
            $display("writeback seen with no instruction in flight");
         end else if (i_wb_valid) begin
            insn = issued.pop_front();
            when = issue_cyc.pop_front();
            if (cyc - when != 2) begin
               o_errors++;
               $display("writeback of insn 0x%08h came %0d cycles after issue instead of 2",
                        insn, cyc - when);
            end
            want = ref_wb(insn);
            compare_field("o_wb_illegal", want.illegal, i_wb_illegal);
            compare_field("o_wb_we", want.we, i_wb_we);
            if (want.we) begin
               compare_field("o_wb_rd", want.rd, i_wb_rd);
               compare_field("o_wb_data", want.data, i_wb_data);
               regs[want.rd] = want.data;
            end
            if (insn[6:0] == 7'b0100011 && !want.illegal)
               apply_store(insn);
            o_checked++;
         end
         if (i_valid) begin
            issued.push_back(i_insn);
            issue_cyc.push_back(cyc);
         end
         cyc++;
      end
      o_pending = issued.size();
   end

endmodule

`default_nettype wire

//--- dv/rv_exec_tb.sv
`timescale 1ns/1ps
`default_nettype none

module rv_exec_tb import rv_core_pkg::*; ();

   localparam int CLK_PERIOD   = 10;
   localparam int RESET_CYCLES = 5;
   localparam int N_RANDOM     = 600;
   localparam int DMEM_WORDS   = 256;
   localparam insn_t ILLEGAL_WORDS [10] = '{
      32'h0000_0000, 32'hffff_ffff, 32'h0000_0063, 32'h0000_006f, 32'h0000_0073,
      32'h4000_1033, 32'h0000_7003, 32'h0000_4023, 32'h0200_0033, 32'h0200_101b
   };

   logic      clk;
   logic      reset;
   logic      in_valid;
   insn_t     in_insn;
   logic      wb_valid;
   logic      wb_illegal;
   logic      wb_we;
   reg_addr_t wb_rd;
   xlen_t     wb_data;
   int        seed;
   insn_t     prog [$];
   logic      prog_vld [$];
   int        prog_len;
   int        n_issued;
   int        mon_errors;
   int        mon_checked;
   int        mon_pending;
   int        errors;

   rv_exec_top #(.DMEM_WORDS(DMEM_WORDS)) UUT (
      .i_clk        (clk),
      .i_reset      (reset),
      .i_valid      (in_valid),
      .i_insn       (in_insn),
      .o_wb_valid   (wb_valid),
      .o_wb_illegal (wb_illegal),
      .o_wb_we      (wb_we),
      .o_wb_rd      (wb_rd),
      .o_wb_data    (wb_data)
   );

   rv_exec_mon #(.DMEM_WORDS(DMEM_WORDS)) u_mon (
      .i_clk        (clk),
      .i_reset      (reset),
      .i_valid      (in_valid),
      .i_insn       (in_insn),
      .i_wb_valid   (wb_valid),
      .i_wb_illegal (wb_illegal),
      .i_wb_we      (wb_we),
      .i_wb_rd      (wb_rd),
      .i_wb_data    (wb_data),
      .o_errors     (mon_errors),
      .o_checked    (mon_checked),
      .o_pending    (mon_pending)
   );

   function automatic int unsigned urand(int unsigned n);
      return $unsigned($random(seed)) % n;
   endfunction

   // mostly a small pool of registers so that dependencies happen often
   function automatic reg_addr_t pick_reg(int unsigned n);
      return 5'((urand(4) != 0) ? urand(8) : urand(n));
   endfunction

   function automatic insn_t enc_r(logic [6:0] f7, reg_addr_t rs2, reg_addr_t rs1,
                                   logic [2:0] f3, reg_addr_t rd, logic [6:0] opc);
      return {f7, rs2, rs1, f3, rd, opc};
   endfunction

   function automatic insn_t enc_i(logic [11:0] imm, reg_addr_t rs1, logic [2:0] f3,
                                   reg_addr_t rd, logic [6:0] opc);
      return {imm, rs1, f3, rd, opc};
   endfunction

   function automatic logic reads_reg(insn_t ins, reg_addr_t r);
      return (r != 5'd0) && (ins[19:15] == r || ins[24:20] == r);
   endfunction

   function automatic insn_t random_insn();
      int unsigned sel;
      logic [2:0]  f3;
      logic [5:0]  sh;
      logic        alt;
      reg_addr_t   rd;
      reg_addr_t   rs1;
      reg_addr_t   rs2;
      logic [11:0] off;
      sel = urand(19);
      f3  = 3'(urand(8));
      sh  = 6'(urand(64));
      alt = 1'(urand(2));
      rd  = pick_reg(31);  // x31 stays the load/store base
      rs1 = pick_reg(32);
      rs2 = pick_reg(32);
      if (sel < 2)
         return {20'(urand(1 << 20)), rd, 7'b0110111};
      if (sel < 6) begin
         if (f3 == 3'b001)
            return enc_i({6'd0, sh}, rs1, f3, rd, 7'b0010011);
         if (f3 == 3'b101)
            return enc_i({1'b0, alt, 4'd0, sh}, rs1, f3, rd, 7'b0010011);
         return enc_i(12'(urand(4096)), rs1, f3, rd, 7'b0010011);
      end
      if (sel < 10)
         return enc_r({1'b0, alt & (f3 == 3'b000 || f3 == 3'b101), 5'd0}, rs2, rs1, f3, rd,
                      7'b0110011);
      if (sel < 14) begin
         f3 = {f3[2], 1'b0, f3[2] | f3[0]};  // 000, 001 or 101, the word forms
         if (sel < 12 && f3 == 3'b000)
            return enc_i(12'(urand(4096)), rs1, f3, rd, 7'b0011011);
         if (sel < 12)
            return enc_i({1'b0, alt & f3[2], 5'd0, sh[4:0]}, rs1, f3, rd, 7'b0011011);
         return enc_r({1'b0, alt & (f3 != 3'b001), 5'd0}, rs2, rs1, f3, rd, 7'b0111011);
      end
      if (sel < 16)
         f3 = 3'(urand(7));
      else
         f3 = {1'b0, f3[1:0]};
      off = 12'(urand(256)) & ~12'((1 << f3[1:0]) - 1);  // aligned to the access size
      if (sel < 16)
         return enc_i(off, 5'd31, f3, rd, 7'b0000011);
      if (sel < 18)
         return enc_r(off[11:5], rs2, 5'd31, f3, off[4:0], 7'b0100011);
      return ILLEGAL_WORDS[urand(10)];
   endfunction

   task automatic emit(logic v, insn_t ins);
      prog.push_back(ins);
      prog_vld.push_back(v);
      if (v)
         n_issued++;
   endtask

   task automatic build_program();
      int        r;
      int        i;
      insn_t     ins;
      reg_addr_t last_ld;
      for (r = 1; r < 31; r++) begin
         emit(1'b1, {20'(urand(1 << 20)), 5'(r), 7'b0110111});
         emit(1'b1, enc_i(12'(urand(4096)), 5'(r), 3'b000, 5'(r), 7'b0010011));
      end
      emit(1'b1, enc_i(12'h100, 5'd0, 3'b000, 5'd31, 7'b0010011));
      for (r = 0; r < 32; r++)  // fill the 32 doublewords that loads can reach
         emit(1'b1, enc_r(7'(r >> 2), 5'(r), 5'd31, 3'b011, {r[1:0], 3'b000}, 7'b0100011));
      last_ld = 5'd0;
      for (i = 0; i < N_RANDOM; i++) begin
         if (urand(16) == 0) begin
            emit(1'b0, insn_t'($random(seed)));
            last_ld = 5'd0;
         end else begin
            do
               ins = random_insn();
            while (reads_reg(ins, last_ld));
            emit(1'b1, ins);
            last_ld = (ins[6:0] == 7'b0000011) ? ins[11:7] : 5'd0;
         end
      end
   endtask

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   initial begin
      wait (prog_len != 0);
      #((prog_len + RESET_CYCLES + 50) * CLK_PERIOD);
      $display("timeout: the run did not end within %0d cycles", prog_len + RESET_CYCLES + 50);
      $display("TESTS FAILED");
      $finish;
   end

   initial begin
      int k;
      reset    = 1'b1;
      in_valid = 1'b0;
      in_insn  = '0;
      seed     = 96121;
      prog_len = 0;
      n_issued = 0;
      build_program();
      prog_len = prog.size();
      repeat (RESET_CYCLES) @(posedge clk);
      reset <= 1'b0;
      for (k = 0; k < prog_len; k++) begin
         @(posedge clk);
         in_valid <= prog_vld[k];
         in_insn  <= prog[k];
      end
      @(posedge clk);
      in_valid <= 1'b0;
      repeat (4) @(posedge clk);
      errors = mon_errors + UUT.u_chk.fail_count;
      if (mon_pending != 0) begin
         errors++;
         $display("%0d issued instructions never produced a writeback", mon_pending);
      end
      $display("run complete: %0d issued, %0d writebacks checked, %0d errors",
               n_issued, mon_checked, errors);
      if (errors == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- list.f
design/rv_core_pkg.sv
design/insn_decode.sv
design/operand_fetch.sv
design/exec_stage.sv
design/lsu.sv
design/rv_exec_top.sv
dv/rv_exec_chk.sv
dv/rv_exec_mon.sv
dv/rv_exec_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the RV64I execution slice testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f --top-module rv_exec_tb \
   && ./obj_dir/Vrv_exec_tb +verilator+error+limit+100 > sim.log 2>&1 \
   || echo "build or simulation did not complete" >> sim.log

cat sim.log
grep -q "^TESTS PASSED$" sim.log && exit 0 || exit 1
